//--- source/tomasuloPkg.sv
/* Tomasulo core shared types */
`default_nettype none

package tomasuloPkg;

    // ALU opcodes in their encoding order
    typedef enum logic [2:0] {
        opAdd = 3'd0,
        opSub = 3'd1,
        opAnd = 3'd2,
        opOr  = 3'd3,
        opXor = 3'd4,
        opSll = 3'd5,
        opSrl = 3'd6,
        opSlt = 3'd7
    } aluOp_t;

    // register zero stands for no destination, so an entry named zero is never occupied
    localparam int nameFree = 0;

    localparam int tagFree = 0;  // no producer pending on a register

endpackage

`default_nettype wire

//--- source/aluUnit.sv
/* Single-cycle integer ALU */
`timescale 1ns/1ps
`default_nettype none

module aluUnit import tomasuloPkg::*; #(
    parameter int dataWidth = 32,
    parameter int tagWidth  = 4,
    parameter int nameWidth = 3
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       issueValid,
    input  wire aluOp_t               issueOp,
    input  wire logic [dataWidth-1:0] issueA,
    input  wire logic [dataWidth-1:0] issueB,
    input  wire logic [tagWidth-1:0]  issueTag,
    input  wire logic [nameWidth-1:0] issueName,
    output logic                      resultValid,
    output logic [tagWidth-1:0]       resultTag,
    output logic [nameWidth-1:0]      resultName,
    output logic [dataWidth-1:0]      resultData
);

    localparam int shiftWidth = $clog2(dataWidth);

    logic [shiftWidth-1:0] shiftAmount;
    logic [dataWidth-1:0]  aluOut;
    logic                  lessThan;

    assign shiftAmount = issueB[shiftWidth-1:0];  // only the low bits of B count
    assign lessThan    = $signed(issueA) < $signed(issueB);

    always_comb begin
        case (issueOp)
            opAdd:   aluOut = issueA + issueB;
            opSub:   aluOut = issueA - issueB;
            opAnd:   aluOut = issueA & issueB;
            opOr:    aluOut = issueA | issueB;
            opXor:   aluOut = issueA ^ issueB;
            opSll:   aluOut = issueA << shiftAmount;
            opSrl:   aluOut = issueA >> shiftAmount;
            opSlt:   aluOut = {{(dataWidth-1){1'b0}}, lessThan};
            default: aluOut = '0;
        endcase
    end

    // resultValid follows the issue strobe one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            resultTag  <= issueTag;
            resultName <= issueName;
            resultData <= aluOut;
        end
    end

endmodule

`default_nettype wire

//--- source/resultBuffer.sv
/* Result buffer with CDB broadcast */
`timescale 1ns/1ps
`default_nettype none

module resultBuffer import tomasuloPkg::*; #(
    parameter int dataWidth   = 32,
    parameter int tagWidth    = 4,
    parameter int nameWidth   = 3,
    parameter int bufferDepth = 4
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       resultValid,
    input  wire logic [tagWidth-1:0]  resultTag,
    input  wire logic [nameWidth-1:0] resultName,
    input  wire logic [dataWidth-1:0] resultData,
    input  wire                       cdbGrant,
    output logic                      cdbValid,
    output logic [nameWidth-1:0]      cdbName,
    output logic [tagWidth-1:0]       cdbTag,
    output logic [dataWidth-1:0]      cdbData,
    output logic                      bufferFull,
    output logic [bufferDepth-1:0]    freeSlots
);

    localparam int countWidth = $clog2(bufferDepth + 1);

    logic [dataWidth-1:0]   slotData [bufferDepth];
    logic [tagWidth-1:0]    slotTag  [bufferDepth];
    logic [nameWidth-1:0]   slotName [bufferDepth];

    logic [bufferDepth-1:0] freeVec;
    logic [bufferDepth-1:0] occVec;
    logic [bufferDepth-1:0] freeLow;
    logic [bufferDepth-1:0] occLow;
    logic [countWidth-1:0]  freeCount;
    logic                   anyOcc;
    logic                   doBroadcast;

    logic [nameWidth-1:0]   bcastName;
    logic [tagWidth-1:0]    bcastTag;
    logic [dataWidth-1:0]   bcastData;

    // a slot is busy exactly when it carries a real register name
    always_comb begin
        for (int i = 0; i < bufferDepth; i++) begin
            freeVec[i] = slotName[i] == nameWidth'(nameFree);
        end
    end

    assign occVec = ~freeVec;

    assign freeLow = freeVec & (-freeVec);  // two's complement trick keeps the lowest set bit
    assign occLow  = occVec & (-occVec);

    assign anyOcc      = |occVec;
    assign doBroadcast = cdbGrant && anyOcc;

    always_comb begin
        freeCount = '0;
        for (int i = 0; i < bufferDepth; i++) begin
            freeCount = freeCount + countWidth'(freeVec[i]);
        end
    end

    // one result may still be inside the ALU, so keep a slot spare for it
    assign bufferFull = freeCount < countWidth'(2);
    assign freeSlots  = freeVec;

    always_comb begin
        bcastName = nameWidth'(nameFree);
        bcastTag  = tagWidth'(tagFree);
        bcastData = '0;
        for (int i = 0; i < bufferDepth; i++) begin
            if (occLow[i]) begin
                bcastName = slotName[i];
                bcastTag  = slotTag[i];
                bcastData = slotData[i];
            end
        end
    end

    // write and free work on disjoint slots, both chosen from the state before the edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bufferDepth; i++) begin
                slotName[i] <= nameWidth'(nameFree);
            end
        end else begin
            for (int i = 0; i < bufferDepth; i++) begin
                if (resultValid && freeLow[i]) begin
                    slotName[i] <= resultName;
                end else if (doBroadcast && occLow[i]) begin
                    slotName[i] <= nameWidth'(nameFree);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < bufferDepth; i++) begin
            if (resultValid && freeLow[i]) begin
                slotTag[i]  <= resultTag;
                slotData[i] <= resultData;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdbValid <= 1'b0;
            cdbName  <= nameWidth'(nameFree);
            cdbTag   <= tagWidth'(tagFree);
            cdbData  <= '0;
        end else begin
            cdbValid <= doBroadcast;
            if (doBroadcast) begin  // fields hold their last value between broadcasts
                cdbName <= bcastName;
                cdbTag  <= bcastTag;
                cdbData <= bcastData;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/regStatusFile.sv
/* Register status file */
`timescale 1ns/1ps
`default_nettype none

module regStatusFile import tomasuloPkg::*; #(
    parameter int dataWidth = 32,
    parameter int tagWidth  = 4,
    parameter int nameWidth = 3
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       issueValid,
    input  wire logic [tagWidth-1:0]  issueTag,
    input  wire logic [nameWidth-1:0] issueName,
    input  wire                       cdbValid,
    input  wire logic [nameWidth-1:0] cdbName,
    input  wire logic [tagWidth-1:0]  cdbTag,
    input  wire logic [dataWidth-1:0] cdbData,
    input  wire logic [nameWidth-1:0] readName,
    output logic [dataWidth-1:0]      readData,
    output logic [tagWidth-1:0]       readTag
);

    localparam int numRegs = 1 << nameWidth;

    logic [dataWidth-1:0] regValue [numRegs];
    logic [tagWidth-1:0]  regTag   [numRegs];
    logic                 cdbLive;

    assign cdbLive = cdbValid && (cdbName != nameWidth'(nameFree));

    // register zero is skipped below, so it keeps its reset value for good
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < numRegs; r++) begin
                regValue[r] <= '0;
                regTag[r]   <= tagWidth'(tagFree);
            end
        end else begin
            for (int r = 1; r < numRegs; r++) begin
                // a broadcast from an older producer finds a different tag and is dropped
                if (cdbLive && cdbName == nameWidth'(r) && regTag[r] == cdbTag) begin
                    regValue[r] <= cdbData;
                    regTag[r]   <= tagWidth'(tagFree);
                end
                if (issueValid && issueName == nameWidth'(r)) begin
                    regTag[r] <= issueTag;  // the new rename overrides a clear at the same edge
                end
            end
        end
    end

    assign readData = regValue[readName];
    assign readTag  = regTag[readName];

endmodule

`default_nettype wire

//--- source/cdbCore.sv
/* CDB broadcast core top */
`timescale 1ns/1ps
`default_nettype none

module cdbCore import tomasuloPkg::*; #(
    parameter int dataWidth   = 32,
    parameter int tagWidth    = 4,
    parameter int nameWidth   = 3,
    parameter int bufferDepth = 4
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       issueValid,
    input  wire aluOp_t               issueOp,
    input  wire logic [dataWidth-1:0] issueA,
    input  wire logic [dataWidth-1:0] issueB,
    input  wire logic [tagWidth-1:0]  issueTag,
    input  wire logic [nameWidth-1:0] issueName,
    input  wire                       cdbGrant,
    input  wire logic [nameWidth-1:0] readName,
    output logic                      cdbValid,
    output logic [nameWidth-1:0]      cdbName,
    output logic [tagWidth-1:0]       cdbTag,
    output logic [dataWidth-1:0]      cdbData,
    output logic                      bufferFull,
    output logic [bufferDepth-1:0]    freeSlots,
    output logic [dataWidth-1:0]      readData,
    output logic [tagWidth-1:0]       readTag
);

    logic                 resultValid;
    logic [tagWidth-1:0]  resultTag;
    logic [nameWidth-1:0] resultName;
    logic [dataWidth-1:0] resultData;

    aluUnit #(
        .dataWidth (dataWidth),
        .tagWidth  (tagWidth),
        .nameWidth (nameWidth)
    ) uAlu (
        .clk         (clk),
        .rst         (rst),
        .issueValid  (issueValid),
        .issueOp     (issueOp),
        .issueA      (issueA),
        .issueB      (issueB),
        .issueTag    (issueTag),
        .issueName   (issueName),
        .resultValid (resultValid),
        .resultTag   (resultTag),
        .resultName  (resultName),
        .resultData  (resultData)
    );

    resultBuffer #(
        .dataWidth   (dataWidth),
        .tagWidth    (tagWidth),
        .nameWidth   (nameWidth),
        .bufferDepth (bufferDepth)
    ) uBuffer (
        .clk         (clk),
        .rst         (rst),
        .resultValid (resultValid),
        .resultTag   (resultTag),
        .resultName  (resultName),
        .resultData  (resultData),
        .cdbGrant    (cdbGrant),
        .cdbValid    (cdbValid),
        .cdbName     (cdbName),
        .cdbTag      (cdbTag),
        .cdbData     (cdbData),
        .bufferFull  (bufferFull),
        .freeSlots   (freeSlots)
    );

    // issue goes here too so the rename is recorded at issue time
    regStatusFile #(
        .dataWidth (dataWidth),
        .tagWidth  (tagWidth),
        .nameWidth (nameWidth)
    ) uRegs (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issueTag   (issueTag),
        .issueName  (issueName),
        .cdbValid   (cdbValid),
        .cdbName    (cdbName),
        .cdbTag     (cdbTag),
        .cdbData    (cdbData),
        .readName   (readName),
        .readData   (readData),
        .readTag    (readTag)
    );

endmodule

`default_nettype wire

//--- dv/cdbModel.svh
/* CDB core reference model */
`ifndef cdbModelSvh
`define cdbModelSvh

string testName = "none";
int    errorCount = 0;
int    checkCount = 0;
logic [15:0] lfsrState = 16'd5979;

// model state that advances once per rising edge
logic [nameWidth-1:0] mSlotName [bufferDepth];
logic [tagWidth-1:0]  mSlotTag  [bufferDepth];
logic [dataWidth-1:0] mSlotData [bufferDepth];
logic                 mAluValid;
logic [tagWidth-1:0]  mAluTag;
logic [nameWidth-1:0] mAluName;
logic [dataWidth-1:0] mAluData;
logic                 mCdbValid;
logic [nameWidth-1:0] mCdbName;
logic [tagWidth-1:0]  mCdbTag;
logic [dataWidth-1:0] mCdbData;
logic [dataWidth-1:0] mRegValue [numRegs];
logic [tagWidth-1:0]  mRegTag   [numRegs];

function automatic logic [dataWidth-1:0] aluRef(input aluOp_t op,
        input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
    int sh;
    sh = b % dataWidth;  // same as keeping the low bits of B
    case (op)
        opAdd:   return a + b;
        opSub:   return a - b;
        opAnd:   return a & b;
        opOr:    return a | b;
        opXor:   return a ^ b;
        opSll:   return a << sh;
        opSrl:   return a >> sh;
        opSlt:   return ($signed(a) < $signed(b)) ? 1 : 0;
        default: return '0;
    endcase
endfunction

// Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsrStep();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
        lfsrState = lfsrState ^ 16'hB400;
    end
    return outBit;
endfunction

function automatic logic [31:0] randomBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsrStep()};
    end
    return r;
endfunction

task automatic checkValue(input string what, input logic [63:0] expected,
        input logic [63:0] actual);
    checkCount++;
    if (expected !== actual) begin
        errorCount++;
        $display("Error in test %s: %s expected %0h, actual %0h",
                 testName, what, expected, actual);
    end
endtask

function automatic int lowestFree();
    for (int i = 0; i < bufferDepth; i++) begin
        if (mSlotName[i] == nameWidth'(nameFree)) return i;
    end
    return -1;
endfunction

function automatic int lowestOccupied();
    for (int i = 0; i < bufferDepth; i++) begin
        if (mSlotName[i] != nameWidth'(nameFree)) return i;
    end
    return -1;
endfunction

function automatic logic [bufferDepth-1:0] modelFreeVec();
    logic [bufferDepth-1:0] v;
    for (int i = 0; i < bufferDepth; i++) begin
        v[i] = mSlotName[i] == nameWidth'(nameFree);
    end
    return v;
endfunction

function automatic void modelReset();
    for (int i = 0; i < bufferDepth; i++) begin
        mSlotName[i] = nameWidth'(nameFree);
    end
    for (int r = 0; r < numRegs; r++) begin
        mRegValue[r] = '0;
        mRegTag[r]   = tagWidth'(tagFree);
    end
    mAluValid = 1'b0;
    mCdbValid = 1'b0;
    mCdbName  = nameWidth'(nameFree);
    mCdbTag   = tagWidth'(tagFree);
    mCdbData  = '0;
endfunction

function automatic void modelStep(input logic iv, input aluOp_t op,
        input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b,
        input logic [tagWidth-1:0] tag, input logic [nameWidth-1:0] name,
        input logic grant);
    int wr;
    int rd;
    wr = lowestFree();
    rd = lowestOccupied();
    // the broadcast of the cycle that ends here reaches the registers
    if (mCdbValid && mCdbName != nameWidth'(nameFree) && mRegTag[mCdbName] == mCdbTag) begin
        mRegValue[mCdbName] = mCdbData;
        mRegTag[mCdbName]   = tagWidth'(tagFree);
    end
    if (iv && name != nameWidth'(nameFree)) begin
        mRegTag[name] = tag;  // a new rename beats a clear at the same edge
    end
    mCdbValid = grant && rd >= 0;
    if (mCdbValid) begin
        mCdbName = mSlotName[rd];
        mCdbTag  = mSlotTag[rd];
        mCdbData = mSlotData[rd];
        mSlotName[rd] = nameWidth'(nameFree);
    end
    if (mAluValid && wr >= 0) begin
        mSlotName[wr] = mAluName;  // a result named zero leaves the slot free
        mSlotTag[wr]  = mAluTag;
        mSlotData[wr] = mAluData;
    end
    mAluValid = iv;
    if (iv) begin
        mAluTag  = tag;
        mAluName = name;
        mAluData = aluRef(op, a, b);
    end
endfunction

`endif

//--- dv/cdbCoreTb.sv
/* CDB core testbench */
`timescale 1ns/1ps
`default_nettype none

module cdbCoreTb import tomasuloPkg::*;;

    localparam int dataWidth   = 32;
    localparam int tagWidth    = 4;
    localparam int nameWidth   = 3;
    localparam int bufferDepth = 4;
    localparam int numRegs     = 1 << nameWidth;

    // rough cycle budget of the five tests
    localparam int testCycles    = 20 + 8 * 8 + 40 + 20 + 240;
    localparam int timeoutCycles = 2 * testCycles + 100;

    logic                   clk;
    logic                   rst;
    logic                   issueValid;
    aluOp_t                 issueOp;
    logic [dataWidth-1:0]   issueA;
    logic [dataWidth-1:0]   issueB;
    logic [tagWidth-1:0]    issueTag;
    logic [nameWidth-1:0]   issueName;
    logic                   cdbGrant;
    logic [nameWidth-1:0]   readName;
    logic                   cdbValid;
    logic [nameWidth-1:0]   cdbName;
    logic [tagWidth-1:0]    cdbTag;
    logic [dataWidth-1:0]   cdbData;
    logic                   bufferFull;
    logic [bufferDepth-1:0] freeSlots;
    logic [dataWidth-1:0]   readData;
    logic [tagWidth-1:0]    readTag;

    logic [tagWidth-1:0]    seenTags [$];
    int                     cycleCount = 0;
    int                     errorsAtStart = 0;

    `include "cdbModel.svh"

    cdbCore #(
        .dataWidth   (dataWidth),
        .tagWidth    (tagWidth),
        .nameWidth   (nameWidth),
        .bufferDepth (bufferDepth)
    ) u_dut (
        .clk (clk), .rst (rst),
        .issueValid (issueValid), .issueOp (issueOp), .issueA (issueA), .issueB (issueB),
        .issueTag (issueTag), .issueName (issueName), .cdbGrant (cdbGrant),
        .readName (readName), .cdbValid (cdbValid), .cdbName (cdbName), .cdbTag (cdbTag),
        .cdbData (cdbData), .bufferFull (bufferFull), .freeSlots (freeSlots),
        .readData (readData), .readTag (readTag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic startTest(input string name);
        testName = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        $display("test %s finished with %0d errors", testName, errorCount - errorsAtStart);
    endtask

    // the issue is sampled at the next rising edge
    task automatic issueOne(input aluOp_t op, input logic [dataWidth-1:0] a,
            input logic [dataWidth-1:0] b, input logic [tagWidth-1:0] tag,
            input logic [nameWidth-1:0] name);
        issueValid = 1'b1;
        issueOp    = op;
        issueA     = a;
        issueB     = b;
        issueTag   = tag;
        issueName  = name;
        nextCycle();
        issueValid = 1'b0;
    endtask

    task automatic waitBroadcast(input int limit, output int edges);
        edges = 1;  // the issue edge counts as the first
        while (cdbValid !== 1'b1 && edges < limit) begin
            nextCycle();
            edges++;
        end
        if (cdbValid !== 1'b1) begin
            errorCount++;
            $display("test %s: no CDB broadcast came within %0d cycles", testName, limit);
        end
    endtask

    task automatic waitDrained(input int limit);
        int n;
        n = 0;
        nextCycle();
        nextCycle();
        while ((freeSlots !== '1 || cdbValid !== 1'b0) && n < limit) begin
            nextCycle();
            n++;
        end
        if (freeSlots !== '1 || cdbValid !== 1'b0) begin
            errorCount++;
            $display("test %s: the result buffer did not drain within %0d cycles", testName, limit);
        end
    endtask

    task automatic compareOutputs();
        logic [bufferDepth-1:0] expFree;
        expFree = modelFreeVec();
        checkCount++;
        if (cdbValid !== mCdbValid) begin
            errorCount++;
            if (cdbValid === 1'b1) begin
                $display("test %s: the DUT broadcast on the CDB with nothing due", testName);
            end else begin
                $display("test %s: an expected CDB broadcast did not appear", testName);
            end
        end else if (mCdbValid) begin
            checkValue("cdbName", mCdbName, cdbName);
            checkValue("cdbTag", mCdbTag, cdbTag);
            checkValue("cdbData", mCdbData, cdbData);
            seenTags.push_back(cdbTag);
        end
        checkValue("freeSlots", expFree, freeSlots);
        checkValue("bufferFull", $countones(expFree) < 2, bufferFull);
        checkValue("readData", mRegValue[readName], readData);
        checkValue("readTag", mRegTag[readName], readTag);
    endtask

    // the model steps on each edge and the outputs are compared mid-cycle
    initial begin
        modelReset();
        forever begin
            @(posedge clk);
            if (rst) begin
                modelReset();
            end else begin
                modelStep(issueValid, issueOp, issueA, issueB, issueTag, issueName, cdbGrant);
            end
            @(negedge clk);
            if (!rst) compareOutputs();
        end
    end

    initial begin
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not end within %0d cycles", timeoutCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int edges;
        int n;
        aluOp_t op;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] oldData;
        logic [2:0] opBits;
        logic [tagWidth-1:0] tag;
        int expTags [5];

        rst = 1'b1;
        issueValid = 1'b0;
        issueOp = opAdd;
        issueA = '0;
        issueB = '0;
        issueTag = '0;
        issueName = '0;
        cdbGrant = 1'b0;
        readName = '0;
        oldData = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        startTest("reset");
        checkValue("cdbValid", 0, cdbValid);
        checkValue("bufferFull", 0, bufferFull);
        checkValue("freeSlots", {bufferDepth{1'b1}}, freeSlots);
        for (int r = 0; r < numRegs; r++) begin
            readName = r;
            #1;
            checkValue("readData", 0, readData);
            checkValue("readTag", tagFree, readTag);
        end
        readName = '0;
        finishTest();

        startTest("alu");
        cdbGrant = 1'b1;
        for (int k = 0; k < 8; k++) begin
            op = aluOp_t'(k[2:0]);
            a  = 32'h8765_4321 ^ (k * 32'h0101_0101);
            b  = 32'h0000_1003 + k * 7;
            issueOne(op, a, b, k + 1, (k % 7) + 1);
            waitBroadcast(10, edges);
            checkValue("issue to broadcast edges", 3, edges);
            checkValue("broadcast data", aluRef(op, a, b), cdbData);
            checkValue("broadcast tag", k + 1, cdbTag);
            if ((k % 7) + 1 == 6) begin
                oldData = aluRef(op, a, b);  // register 6 holds this until the tag test
            end
            nextCycle();
            checkValue("single broadcast", 0, cdbValid);
            nextCycle();
        end
        finishTest();

        startTest("backpressure");
        cdbGrant = 1'b0;
        n = 0;
        while (!bufferFull && n < 2 * bufferDepth) begin
            issueOne(opAdd, n * 3, 100 + n, n + 1, n + 1);
            n++;
        end
        checkValue("issues until full", bufferDepth, n);
        repeat (3) nextCycle();
        checkValue("freeSlots when full", 0, freeSlots);
        seenTags.delete();
        cdbGrant = 1'b1;
        n = 0;
        while (bufferFull && n < 10) begin
            nextCycle();
            n++;
        end
        issueOne(opXor, 32'h00FF_00FF, 32'h0F0F_0F0F, 6, 5);  // lands in the reused slot 0
        waitDrained(20);
        expTags = '{1, 2, 3, 4, 6};
        checkValue("broadcast count", 5, seenTags.size());
        for (int i = 0; i < 5 && i < seenTags.size(); i++) begin
            checkValue("broadcast order", expTags[i], seenTags[i]);
        end
        finishTest();

        startTest("tagmatch");
        cdbGrant = 1'b0;
        readName = 6;
        issueOne(opAdd, 11, 22, 3, 6);
        issueOne(opSub, 500, 123, 5, 6);
        nextCycle();
        nextCycle();
        checkValue("pending tag", 5, readTag);
        cdbGrant = 1'b1;
        waitBroadcast(10, edges);
        checkValue("stale broadcast tag", 3, cdbTag);
        nextCycle();
        checkValue("tag after stale broadcast", 5, readTag);
        checkValue("value after stale broadcast", oldData, readData);
        checkValue("second broadcast", 1, cdbValid);
        checkValue("second broadcast tag", 5, cdbTag);
        nextCycle();
        checkValue("value after match", aluRef(opSub, 500, 123), readData);
        checkValue("tag after match", tagFree, readTag);
        finishTest();

        startTest("random");
        for (int c = 0; c < 200; c++) begin
            cdbGrant = lfsrStep();
            readName = randomBits(nameWidth);
            if (lfsrStep() && !bufferFull) begin
                opBits = randomBits(3);
                tag    = randomBits(tagWidth);
                if (tag == tagWidth'(tagFree)) tag = 1;
                issueValid = 1'b1;
                issueOp    = aluOp_t'(opBits);
                issueA     = randomBits(dataWidth);
                issueB     = randomBits(dataWidth);
                issueTag   = tag;
                issueName  = randomBits(nameWidth);
            end else begin
                issueValid = 1'b0;
            end
            nextCycle();
        end
        issueValid = 1'b0;
        cdbGrant = 1'b1;
        waitDrained(30);
        finishTest();

        $display("tests 5, checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+dv
source/tomasuloPkg.sv
source/aluUnit.sv
source/resultBuffer.sv
source/regStatusFile.sv
source/cdbCore.sv
dv/cdbCoreTb.sv
